// ==== logic/knight_settings.svh ====
`ifndef KNIGHT_SETTINGS_SVH
`define KNIGHT_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Serial link timing
////////////////////////////////////////////////////////////

// Clock cycles per UART bit (short for simulation)
`define BAUD_DIV 16

////////////////////////////////////////////////////////////
// Motor drive timing
////////////////////////////////////////////////////////////

// Cycles in one PWM period
`define PWM_PERIOD 64

// Drive time for a single square of travel
`define SQUARE_CYCLES 256

////////////////////////////////////////////////////////////
// Response bytes back to the remote
////////////////////////////////////////////////////////////

`define RESP_ACK 8'hA5
`define RESP_ERR 8'hEE

`endif

// ==== logic/knightCmdPkg.sv ====
package knightCmdPkg;

  ////////////////////////////////////////////////////////////
  // Command classes in the top nibble of every command
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    CAL_GYRO = 4'h2,
    MOVE     = 4'h4,
    TOUR     = 4'h6
  } opcodeT;

  // Heading codes carried in the middle byte of a move
  typedef enum logic [7:0] {
    NORTH = 8'h00,
    WEST  = 8'h3F,
    SOUTH = 8'h7F,
    EAST  = 8'hBF
  } headingT;

  // Move view of the command word
  typedef struct packed {
    opcodeT     opcode;
    headingT    heading;
    logic [3:0] squares;
  } moveFieldsT;

  // Position view, used by TOUR to place the knight
  typedef struct packed {
    opcodeT     opcode;
    logic [3:0] unused;
    logic [3:0] x;
    logic [3:0] y;
  } posFieldsT;

  // One 16 bit word, decoded as either a move or a position
  typedef union packed {
    moveFieldsT  move;
    posFieldsT   pos;
    logic [15:0] raw;
  } cmdWordT;

endpackage

// ==== logic/knightDrivePkg.sv ====
package knightDrivePkg;

  // High time within one PWM period
  typedef logic [5:0] dutyT;

  // What the command side hands to the motor drive
  typedef struct packed {
    logic active;
    dutyT lft;
    dutyT rght;
  } drivePairT;

  // Fast and slow wheel settings
  localparam dutyT DUTY_FAST = 6'd48;
  localparam dutyT DUTY_SLOW = 6'd16;

  ////////////////////////////////////////////////////////////
  // Duty table per heading
  ////////////////////////////////////////////////////////////
  // Unknown heading comes back inactive so the caller can flag it
  function automatic drivePairT headingDuty(input knightCmdPkg::headingT heading);
    drivePairT pair;
    pair.active = 1'b1;
    case (heading)
      knightCmdPkg::NORTH: begin pair.lft = DUTY_FAST; pair.rght = DUTY_FAST; end
      knightCmdPkg::SOUTH: begin pair.lft = DUTY_SLOW; pair.rght = DUTY_SLOW; end
      knightCmdPkg::EAST:  begin pair.lft = DUTY_FAST; pair.rght = DUTY_SLOW; end
      knightCmdPkg::WEST:  begin pair.lft = DUTY_SLOW; pair.rght = DUTY_FAST; end
      default: begin
        pair.active = 1'b0;
        pair.lft    = '0;
        pair.rght   = '0;
      end
    endcase
    return pair;
  endfunction

endpackage

// ==== logic/uartLink.sv ====
`timescale 1ns/100ps
`include "knight_settings.svh"

module uartLink (
  input  logic       clk,
  input  logic       arstN,
  input  logic       RX,
  output logic       TX,
  output logic [7:0] rxByte,
  output logic       rxValid,
  input  logic [7:0] txByte,
  input  logic       txSend,
  output logic       txBusy
);

  localparam int BAUD  = `BAUD_DIV;
  localparam int CNT_W = $clog2(BAUD);

  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(BAUD - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BAUD / 2 - 1);

  ////////////////////////////////////////////////////////////
  // Receiver
  ////////////////////////////////////////////////////////////
  logic             rxMeta;
  logic             rxSync;
  logic             rxBusy;
  logic [CNT_W-1:0] rxBaudCnt;
  logic [3:0]       rxBitCnt;
  logic [7:0]       rxShift;

  // Two flop chain on the asynchronous serial input
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= RX;
      rxSync <= rxMeta;
    end
  end

  // Sample points at 0.5, 1.5 ... 9.5 bit times after the start edge
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rxBusy    <= 1'b0;
      rxBaudCnt <= '0;
      rxBitCnt  <= '0;
      rxValid   <= 1'b0;
    end else begin
      rxValid <= 1'b0;
      if (!rxBusy) begin
        // Falling edge of the start bit
        if (!rxSync) begin
          rxBusy    <= 1'b1;
          rxBaudCnt <= HALF_LAST;
          rxBitCnt  <= '0;
        end
      end else if (rxBaudCnt != '0) begin
        rxBaudCnt <= rxBaudCnt - 1'b1;
      end else begin
        rxBaudCnt <= BIT_LAST;
        rxBitCnt  <= rxBitCnt + 1'b1;
        if (rxBitCnt == 4'd0) begin
          // Glitch, not a real start bit
          if (rxSync) rxBusy <= 1'b0;
        end else if (rxBitCnt == 4'd9) begin
          // Stop bit must be high for a good frame
          rxBusy  <= 1'b0;
          rxValid <= rxSync;
        end
      end
    end
  end

  // Data shifts in LSB first
  always_ff @(posedge clk) begin
    if (rxBusy && rxBaudCnt == '0 && rxBitCnt != 4'd0 && rxBitCnt != 4'd9) begin
      rxShift <= {rxSync, rxShift[7:1]};
    end
  end

  assign rxByte = rxShift;

  ////////////////////////////////////////////////////////////
  // Transmitter
  ////////////////////////////////////////////////////////////
  logic [CNT_W-1:0] txBaudCnt;
  logic [3:0]       txBitCnt;
  logic [9:0]       txShift;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      txBusy    <= 1'b0;
      txBaudCnt <= '0;
      txBitCnt  <= '0;
    end else if (!txBusy) begin
      if (txSend) begin
        txBusy    <= 1'b1;
        txBaudCnt <= BIT_LAST;
        txBitCnt  <= '0;
      end
    end else if (txBaudCnt != '0) begin
      txBaudCnt <= txBaudCnt - 1'b1;
    end else begin
      txBaudCnt <= BIT_LAST;
      txBitCnt  <= txBitCnt + 1'b1;
      // Last cell is the stop bit
      if (txBitCnt == 4'd9) txBusy <= 1'b0;
    end
  end

  // Frame is stop, data, start with start bit at the bottom
  always_ff @(posedge clk) begin
    if (!txBusy && txSend) begin
      txShift <= {1'b1, txByte, 1'b0};
    end else if (txBusy && txBaudCnt == '0) begin
      txShift <= {1'b1, txShift[9:1]};
    end
  end

  // Line idles high
  assign TX = txBusy ? txShift[0] : 1'b1;

endmodule

// ==== logic/cmdProc.sv ====
`timescale 1ns/100ps
`include "knight_settings.svh"

module cmdProc (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic [7:0]                rxByte,
  input  logic                      rxValid,
  output logic [7:0]                txByte,
  output logic                      txSend,
  input  logic                      txBusy,
  output knightDrivePkg::drivePairT drive
);

  // Longest move is 15 squares
  localparam int MAX_CYCLES = 15 * `SQUARE_CYCLES;
  localparam int MOVE_W     = $clog2(MAX_CYCLES + 1);

  typedef enum logic [2:0] {
    WAIT_HI,
    WAIT_LO,
    DECODE,
    MOVING,
    RESPOND
  } stateT;

  stateT                     state;
  knightCmdPkg::cmdWordT     cmd;
  logic [MOVE_W-1:0]         moveCnt;
  logic [3:0]                posX;
  logic [3:0]                posY;
  logic [3:0]                nextX;
  logic [3:0]                nextY;
  logic [7:0]                decodeResp;
  logic                      moveDone;
  knightDrivePkg::drivePairT moveDrive;

  // Duty pair for the heading in the held command
  assign moveDrive = knightDrivePkg::headingDuty(cmd.move.heading);

  assign moveDone = (state == MOVING) && (moveCnt == MOVE_W'(1));

  ////////////////////////////////////////////////////////////
  // Position after the current move, wraps modulo 16
  ////////////////////////////////////////////////////////////
  always_comb begin
    nextX = posX;
    nextY = posY;
    case (cmd.move.heading)
      knightCmdPkg::NORTH: nextY = posY + cmd.move.squares;
      knightCmdPkg::SOUTH: nextY = posY - cmd.move.squares;
      knightCmdPkg::EAST:  nextX = posX + cmd.move.squares;
      knightCmdPkg::WEST:  nextX = posX - cmd.move.squares;
      default: ;
    endcase
  end

  // Answer for commands that respond right after decode
  always_comb begin
    case (cmd.move.opcode)
      knightCmdPkg::CAL_GYRO,
      knightCmdPkg::TOUR: decodeResp = `RESP_ACK;
      // Zero square move reports the current square
      knightCmdPkg::MOVE: decodeResp = moveDrive.active ? {posX, posY} : `RESP_ERR;
      default:            decodeResp = `RESP_ERR;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Command bytes and response byte
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    // High byte first
    if (state == WAIT_HI && rxValid) cmd.raw[15:8] <= rxByte;
    if (state == WAIT_LO && rxValid) cmd.raw[7:0] <= rxByte;
    if (state == DECODE) txByte <= decodeResp;
    // Moves answer with the new square, x high nibble
    if (moveDone) txByte <= {nextX, nextY};
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= WAIT_HI;
      moveCnt <= '0;
      posX    <= '0;
      posY    <= '0;
      drive   <= '0;
      txSend  <= 1'b0;
    end else begin
      txSend <= 1'b0;
      case (state)
        WAIT_HI: if (rxValid) state <= WAIT_LO;
        WAIT_LO: if (rxValid) state <= DECODE;
        DECODE: begin
          state <= RESPOND;
          case (cmd.move.opcode)
            knightCmdPkg::TOUR: begin
              posX <= cmd.pos.x;
              posY <= cmd.pos.y;
            end
            knightCmdPkg::MOVE: begin
              // Bad heading or zero squares go straight to the answer
              if (moveDrive.active && cmd.move.squares != 4'd0) begin
                drive   <= moveDrive;
                moveCnt <= MOVE_W'(cmd.move.squares * `SQUARE_CYCLES);
                state   <= MOVING;
              end
            end
            default: ;
          endcase
        end
        MOVING: begin
          if (moveDone) begin
            drive.active <= 1'b0;
            posX         <= nextX;
            posY         <= nextY;
            state        <= RESPOND;
          end else begin
            moveCnt <= moveCnt - 1'b1;
          end
        end
        RESPOND: begin
          // One response byte, sent once the link is free
          if (!txBusy) begin
            txSend <= 1'b1;
            state  <= WAIT_HI;
          end
        end
        default: state <= WAIT_HI;
      endcase
    end
  end

endmodule

// ==== logic/motorPwm.sv ====
`timescale 1ns/100ps
`include "knight_settings.svh"

module motorPwm (
  input  logic                      clk,
  input  logic                      arstN,
  input  knightDrivePkg::drivePairT drive,
  output logic                      lftPWM1,
  output logic                      lftPWM2,
  output logic                      rghtPWM1,
  output logic                      rghtPWM2
);

  localparam knightDrivePkg::dutyT CNT_LAST = knightDrivePkg::dutyT'(`PWM_PERIOD - 1);

  logic                 activeQ;
  knightDrivePkg::dutyT pwmCnt;
  knightDrivePkg::dutyT cntNow;

  // New move starts the period at zero so it opens with the high phase
  assign cntNow = (drive.active && !activeQ) ? '0 : pwmCnt;

  ////////////////////////////////////////////////////////////
  // Period counter and registered outputs
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      activeQ  <= 1'b0;
      pwmCnt   <= '0;
      lftPWM1  <= 1'b0;
      lftPWM2  <= 1'b0;
      rghtPWM1 <= 1'b0;
      rghtPWM2 <= 1'b0;
    end else begin
      activeQ <= drive.active;
      pwmCnt  <= (cntNow == CNT_LAST) ? '0 : cntNow + 1'b1;
      // PWM1 during the duty, PWM2 for the rest
      // Everything low when idle
      lftPWM1  <= drive.active && (cntNow < drive.lft);
      lftPWM2  <= drive.active && !(cntNow < drive.lft);
      rghtPWM1 <= drive.active && (cntNow < drive.rght);
      rghtPWM2 <= drive.active && !(cntNow < drive.rght);
    end
  end

endmodule

// ==== logic/KnightsTour.sv ====
`timescale 1ns/100ps

module KnightsTour (
  input  logic clk,
  input  logic arstN,
  input  logic RX,
  output logic TX,
  output logic lftPWM1,
  output logic lftPWM2,
  output logic rghtPWM1,
  output logic rghtPWM2
);

  ////////////////////////////////////////////////////////////
  // Internal byte paths and drive request
  ////////////////////////////////////////////////////////////
  logic [7:0]                rxByte;
  logic                      rxValid;
  logic [7:0]                txByte;
  logic                      txSend;
  logic                      txBusy;
  knightDrivePkg::drivePairT drive;

  // Serial link to the remote
  uartLink iLink (
    .clk(clk), .arstN(arstN), .RX(RX), .TX(TX),
    .rxByte(rxByte), .rxValid(rxValid),
    .txByte(txByte), .txSend(txSend), .txBusy(txBusy)
  );

  // Command decode, move timing and position
  cmdProc iProc (
    .clk(clk), .arstN(arstN),
    .rxByte(rxByte), .rxValid(rxValid),
    .txByte(txByte), .txSend(txSend), .txBusy(txBusy),
    .drive(drive)
  );

  // Complementary PWM pairs for both wheels
  motorPwm iPwm (
    .clk(clk), .arstN(arstN), .drive(drive),
    .lftPWM1(lftPWM1), .lftPWM2(lftPWM2),
    .rghtPWM1(rghtPWM1), .rghtPWM2(rghtPWM2)
  );

endmodule

// ==== test/KnightsTour_sva.sv ====
`timescale 1ns/100ps

module KnightsTour_sva (
  input logic                      clk,
  input logic                      arstN,
  input logic                      TX,
  input logic                      lftPWM1,
  input logic                      lftPWM2,
  input logic                      rghtPWM1,
  input logic                      rghtPWM2,
  input knightDrivePkg::drivePairT drive
);

  ////////////////////////////////////////////////////////////
  // Complementary pairs never overlap
  ////////////////////////////////////////////////////////////
  lftExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(lftPWM1 && lftPWM2)) else $error("left PWM pair high together");

  rghtExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(rghtPWM1 && rghtPWM2)) else $error("right PWM pair high together");

  // Outputs lag drive by one cycle
  idleLow: assert property (@(posedge clk) disable iff (!arstN)
    !$past(drive.active) |-> !(lftPWM1 || lftPWM2 || rghtPWM1 || rghtPWM2))
    else $error("PWM output high while drive inactive");

  // Serial line idles high once out of reset
  txIdle: assert property (@(posedge clk) $rose(arstN) |=> TX)
    else $error("TX low right after reset");

endmodule

bind KnightsTour KnightsTour_sva iSva (
  .clk(clk), .arstN(arstN), .TX(TX),
  .lftPWM1(lftPWM1), .lftPWM2(lftPWM2),
  .rghtPWM1(rghtPWM1), .rghtPWM2(rghtPWM2),
  .drive(drive)
);

// ==== test/KnightsTour_tb.sv ====
`timescale 1ns/100ps
`include "knight_settings.svh"

module KnightsTour_tb;

  localparam int BIT_CYCLES = `BAUD_DIV;
  localparam int WAIT_LIMIT = 400;

  logic        clk;
  logic        arstN;
  logic        RX;
  logic        TX;
  logic        lftPWM1;
  logic        lftPWM2;
  logic        rghtPWM1;
  logic        rghtPWM2;
  logic [15:0] lfsr;
  logic [3:0]  modelX;
  logic [3:0]  modelY;

  KnightsTour i_dut (
    .clk(clk), .arstN(arstN), .RX(RX), .TX(TX),
    .lftPWM1(lftPWM1), .lftPWM2(lftPWM2),
    .rghtPWM1(rghtPWM1), .rghtPWM2(rghtPWM2)
  );

  // 8 ns period
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Failure reporting and value checks
  ////////////////////////////////////////////////////////////
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [15:0] got,
                            input logic [15:0] expected);
    if (got !== expected) begin
      abortRun($sformatf("error %s: got %h, expected %h", name, got, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Random bits from a 16 bit Galois LFSR
  ////////////////////////////////////////////////////////////
  function automatic logic [15:0] galoisStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galoisStep(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model of position and wheel duties
  ////////////////////////////////////////////////////////////
  function automatic logic [7:0] headingCode(input logic [1:0] idx);
    case (idx)
      2'd0:    return knightCmdPkg::NORTH;
      2'd1:    return knightCmdPkg::WEST;
      2'd2:    return knightCmdPkg::SOUTH;
      default: return knightCmdPkg::EAST;
    endcase
  endfunction

  // Left duty in the upper six bits
  function automatic logic [11:0] modelDuty(input logic [7:0] heading);
    case (heading)
      knightCmdPkg::NORTH: return {6'd48, 6'd48};
      knightCmdPkg::SOUTH: return {6'd16, 6'd16};
      knightCmdPkg::EAST:  return {6'd48, 6'd16};
      default:             return {6'd16, 6'd48};
    endcase
  endfunction

  // Board wraps modulo 16 through the 4 bit width
  task automatic applyMove(input logic [7:0] heading, input logic [3:0] squares);
    case (heading)
      knightCmdPkg::NORTH: modelY = modelY + squares;
      knightCmdPkg::SOUTH: modelY = modelY - squares;
      knightCmdPkg::EAST:  modelX = modelX + squares;
      default:             modelX = modelX - squares;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Remote UART model
  ////////////////////////////////////////////////////////////
  // Start, eight data bits LSB first, stop
  task automatic sendFrame(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      RX <= frame[i];
      repeat (BIT_CYCLES - 1) @(posedge clk);
    end
    @(posedge clk);
  endtask

  task automatic sendCommand(input logic [15:0] word);
    sendFrame(word[15:8]);
    sendFrame(word[7:0]);
  endtask

  // Samples TX near the middle of each bit cell
  task automatic receiveFrame(output logic [7:0] data, input int limit);
    int         waited;
    logic [7:0] bits;
    waited = 0;
    @(negedge clk);
    while (TX !== 1'b0) begin
      if (waited >= limit) abortRun("timeout waiting for a start bit on TX");
      waited++;
      @(negedge clk);
    end
    repeat (BIT_CYCLES / 2) @(negedge clk);
    if (TX !== 1'b0) abortRun("start bit on TX ended early");
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CYCLES) @(negedge clk);
      bits[i] = TX;
    end
    repeat (BIT_CYCLES) @(negedge clk);
    if (TX !== 1'b1) abortRun("stop bit on TX was not high");
    data = bits;
  endtask

  ////////////////////////////////////////////////////////////
  // PWM measurement over one full period
  ////////////////////////////////////////////////////////////
  task automatic measurePwm(input logic [5:0] expLft, input logic [5:0] expRght);
    int waited;
    int highL1;
    int highL2;
    int highR1;
    int highR2;
    waited = 0;
    highL1 = 0;
    highL2 = 0;
    highR1 = 0;
    highR2 = 0;
    @(negedge clk);
    while (!(lftPWM1 || lftPWM2 || rghtPWM1 || rghtPWM2)) begin
      if (waited >= WAIT_LIMIT) abortRun("timeout waiting for the motor drive to start");
      waited++;
      @(negedge clk);
    end
    for (int i = 0; i < `PWM_PERIOD; i++) begin
      highL1 += int'(lftPWM1);
      highL2 += int'(lftPWM2);
      highR1 += int'(rghtPWM1);
      highR2 += int'(rghtPWM2);
      @(negedge clk);
    end
    checkValue("lftPWM1 high cycles", 16'(highL1), 16'(expLft));
    checkValue("lftPWM2 high cycles", 16'(highL2), 16'(`PWM_PERIOD - int'(expLft)));
    checkValue("rghtPWM1 high cycles", 16'(highR1), 16'(expRght));
    checkValue("rghtPWM2 high cycles", 16'(highR2), 16'(`PWM_PERIOD - int'(expRght)));
  endtask

  ////////////////////////////////////////////////////////////
  // Command sequences
  ////////////////////////////////////////////////////////////
  // Answer to a valid heading is the new square
  task automatic runMove(input logic [7:0] heading, input logic [3:0] squares);
    logic [7:0]  resp;
    logic [11:0] duty;
    sendCommand({knightCmdPkg::MOVE, heading, squares});
    applyMove(heading, squares);
    if (squares != 4'd0) begin
      duty = modelDuty(heading);
      measurePwm(duty[11:6], duty[5:0]);
    end
    receiveFrame(resp, int'(squares) * `SQUARE_CYCLES + WAIT_LIMIT);
    checkValue("move response", 16'(resp), 16'({modelX, modelY}));
  endtask

  task automatic expectReply(input string name, input logic [15:0] word,
                             input logic [7:0] expected);
    logic [7:0] resp;
    sendCommand(word);
    receiveFrame(resp, WAIT_LIMIT);
    checkValue(name, 16'(resp), 16'(expected));
  endtask

  initial begin
    logic [11:0] lowBits;
    logic [3:0]  op;
    logic [7:0]  hd;
    logic [3:0]  sq;
    clk    = 1'b0;
    arstN  = 1'b0;
    RX     = 1'b1;
    lfsr   = 16'd59;
    modelX = '0;
    modelY = '0;
    repeat (2) @(posedge clk);
    arstN <= 1'b1;

    // Quiet line and motors after reset
    for (int i = 0; i < 100; i++) begin
      @(negedge clk);
      checkValue("TX", 16'(TX), 16'h1);
      checkValue("PWM outputs", 16'({lftPWM1, lftPWM2, rghtPWM1, rghtPWM2}), 16'h0);
    end

    lowBits = 12'(randBits(12));
    expectReply("CAL_GYRO response", {knightCmdPkg::CAL_GYRO, lowBits}, `RESP_ACK);

    // Place the knight, then confirm with a zero square move
    modelX  = 4'(randBits(4));
    modelY  = 4'(randBits(4));
    lowBits = {4'(randBits(4)), modelX, modelY};
    expectReply("TOUR response", {knightCmdPkg::TOUR, lowBits}, `RESP_ACK);
    runMove(headingCode(2'(randBits(2))), 4'd0);

    // 1 to 3 squares per move
    for (int i = 0; i < 20; i++) begin
      hd = headingCode(2'(randBits(2)));
      sq = 4'(randBits(2) % 16'd3) + 4'd1;
      runMove(hd, sq);
    end

    // Corner start so every heading wraps the board
    modelX = 4'hF;
    modelY = 4'h0;
    expectReply("TOUR response", {knightCmdPkg::TOUR, 4'h0, modelX, modelY}, `RESP_ACK);
    runMove(knightCmdPkg::EAST, 4'd1);
    runMove(knightCmdPkg::SOUTH, 4'd2);
    runMove(knightCmdPkg::WEST, 4'd3);
    runMove(knightCmdPkg::NORTH, 4'd3);

    for (int i = 0; i < 4; i++) begin
      op = 4'(randBits(4));
      // Nudge a known opcode to an unknown neighbour
      if (op == 4'h2 || op == 4'h4 || op == 4'h6) op = op ^ 4'h1;
      lowBits = 12'(randBits(12));
      expectReply("unknown opcode response", {op, lowBits}, `RESP_ERR);
    end
    for (int i = 0; i < 4; i++) begin
      hd = 8'(randBits(8));
      if (hd == 8'h00 || hd == 8'h3F || hd == 8'h7F || hd == 8'hBF) hd = hd ^ 8'h01;
      sq = 4'(randBits(4));
      expectReply("bad heading response", {knightCmdPkg::MOVE, hd, sq}, `RESP_ERR);
    end
    // Position must be untouched by the rejected commands
    runMove(headingCode(2'(randBits(2))), 4'd0);

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== KnightsTour.f ====
+incdir+logic
logic/knightCmdPkg.sv
logic/knightDrivePkg.sv
logic/uartLink.sv
logic/cmdProc.sv
logic/motorPwm.sv
logic/KnightsTour.sv
test/KnightsTour_sva.sv
test/KnightsTour_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the KnightsTour testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module KnightsTour_tb \
  -f KnightsTour.f -o simKnightsTour
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simKnightsTour)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
